// ==== files.f ====
+incdir+.
host_domain_pkg.sv
pmu_cfg_port.sv
pmu_counter_bank.sv
host_domain.sv
host_domain_checker.sv
host_domain_tb.sv

// ==== host_domain.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host domain top
// LLC event monitor behind a config port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "host_domain_config.svh"

module host_domain (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [`NUM_LLC_EVENTS-1:0] llc_events_i,
  input  logic                       cfg_wr_valid_i,
  input  logic [`PMU_CFG_AW-1:0]     cfg_wr_addr_i,
  input  logic [`PMU_CFG_DW-1:0]     cfg_wr_data_i,
  output logic                       cfg_wr_ready_o,
  output logic                       cfg_wr_resp_valid_o,
  output logic [1:0]                 cfg_wr_resp_o,
  input  logic                       cfg_wr_resp_ready_i,
  input  logic                       cfg_rd_valid_i,
  input  logic [`PMU_CFG_AW-1:0]     cfg_rd_addr_i,
  output logic                       cfg_rd_ready_o,
  output logic                       cfg_rd_resp_valid_o,
  output logic [`PMU_CFG_DW-1:0]     cfg_rd_data_o,
  output logic [1:0]                 cfg_rd_resp_o,
  input  logic                       cfg_rd_resp_ready_i,
  output logic                       pmu_irq_o
);
  import host_domain_pkg::*;

  logic                                           ctrl_we;
  logic                                           thresh_we;
  logic                                           status_clr_we;
  pmu_cfg_word_u                                  cfg_wdata;
  logic [`NUM_LLC_EVENTS-1:0]                     ctrl_q;
  logic [`PMU_CNT_WIDTH-1:0]                      thresh_q;
  logic [`NUM_LLC_EVENTS-1:0]                     status_q;
  logic [`NUM_LLC_EVENTS-1:0][`PMU_CNT_WIDTH-1:0] cnt_q;

  pmu_cfg_port i_pmu_cfg_port (
    .clk_i               ( clk_i               ),
    .rst_n_i             ( rst_n_i             ),
    .cfg_wr_valid_i      ( cfg_wr_valid_i      ),
    .cfg_wr_addr_i       ( cfg_wr_addr_i       ),
    .cfg_wr_data_i       ( cfg_wr_data_i       ),
    .cfg_wr_ready_o      ( cfg_wr_ready_o      ),
    .cfg_wr_resp_valid_o ( cfg_wr_resp_valid_o ),
    .cfg_wr_resp_o       ( cfg_wr_resp_o       ),
    .cfg_wr_resp_ready_i ( cfg_wr_resp_ready_i ),
    .cfg_rd_valid_i      ( cfg_rd_valid_i      ),
    .cfg_rd_addr_i       ( cfg_rd_addr_i       ),
    .cfg_rd_ready_o      ( cfg_rd_ready_o      ),
    .cfg_rd_resp_valid_o ( cfg_rd_resp_valid_o ),
    .cfg_rd_data_o       ( cfg_rd_data_o       ),
    .cfg_rd_resp_o       ( cfg_rd_resp_o       ),
    .cfg_rd_resp_ready_i ( cfg_rd_resp_ready_i ),
    .ctrl_we_o           ( ctrl_we             ),
    .thresh_we_o         ( thresh_we           ),
    .status_clr_we_o     ( status_clr_we       ),
    .cfg_wdata_o         ( cfg_wdata           ),
    .ctrl_q_i            ( ctrl_q              ),
    .thresh_q_i          ( thresh_q            ),
    .status_q_i          ( status_q            ),
    .cnt_q_i             ( cnt_q               )
  );

  pmu_counter_bank i_pmu_counter_bank (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .llc_events_i    ( llc_events_i  ),
    .ctrl_we_i       ( ctrl_we       ),
    .thresh_we_i     ( thresh_we     ),
    .status_clr_we_i ( status_clr_we ),
    .cfg_wdata_i     ( cfg_wdata     ),
    .ctrl_q_o        ( ctrl_q        ),
    .thresh_q_o      ( thresh_q      ),
    .status_q_o      ( status_q      ),
    .cnt_q_o         ( cnt_q         ),
    .pmu_irq_o       ( pmu_irq_o     )
  );

endmodule

// ==== host_domain_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PMU response checker
// Matches config responses and the
// interrupt against expected values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module host_domain_checker (
  input logic        clk_i,
  input logic        wr_ready_i,
  input logic        wr_resp_valid_i,
  input logic        wr_resp_ready_i,
  input logic [1:0]  wr_resp_i,
  input logic        rd_ready_i,
  input logic        rd_resp_valid_i,
  input logic        rd_resp_ready_i,
  input logic [31:0] rd_data_i,
  input logic [1:0]  rd_resp_i,
  input logic        irq_i
);

  int          pass_cnt = 0;
  int          fail_cnt = 0;
  // Write entries are {addr, code}, read entries {addr, data, code}
  logic [9:0]  wr_exp_q[$];
  logic [41:0] rd_exp_q[$];
  logic [9:0]  wr_exp;
  logic [41:0] rd_exp;
  bit          ok;

  function automatic bit values_match(input string sig, input logic [31:0] exp,
                                      input logic [31:0] act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %h got %h", $time, sig, exp, act);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic tally(input bit good, input string what);
    if (good) begin
      pass_cnt++;
      $display("%s: ok", what);
    end else begin
      fail_cnt++;
      $display("%s: FAILED", what);
    end
  endtask

  task automatic note_failure(input string what);
    fail_cnt++;
    $display("failure at %0t: %s", $time, what);
  endtask

  task automatic expect_write(input logic [7:0] addr, input logic [1:0] resp);
    wr_exp_q.push_back({addr, resp});
  endtask

  task automatic expect_read(input logic [7:0] addr, input logic [31:0] data,
                             input logic [1:0] resp);
    rd_exp_q.push_back({addr, data, resp});
  endtask

  task automatic check_irq(input logic level);
    tally(values_match("pmu_irq_o", {31'd0, level}, {31'd0, irq_i}),
          $sformatf("irq level %0b", level));
  endtask

  task automatic print_counts();
    if (wr_exp_q.size() + rd_exp_q.size() != 0) begin
      note_failure("some issued requests never got a response");
    end
    $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
  endtask

  // Inputs settle 2 ns after the rising edge, so the falling edge sees the handshake
  // A response still pending must hold its request channel off
  always @(negedge clk_i) begin
    if (wr_resp_valid_i && wr_resp_ready_i) begin
      if (wr_exp_q.size() == 0) begin
        note_failure("write response without a pending write request");
      end else begin
        wr_exp = wr_exp_q.pop_front();
        ok = values_match("cfg_wr_resp_o", {30'd0, wr_exp[1:0]}, {30'd0, wr_resp_i}) &
             values_match("cfg_wr_ready_o", 32'd0, {31'd0, wr_ready_i});
        tally(ok, $sformatf("write %h", wr_exp[9:2]));
      end
    end
    if (rd_resp_valid_i && rd_resp_ready_i) begin
      if (rd_exp_q.size() == 0) begin
        note_failure("read response without a pending read request");
      end else begin
        rd_exp = rd_exp_q.pop_front();
        ok = values_match("cfg_rd_data_o", rd_exp[33:2], rd_data_i) &
             values_match("cfg_rd_resp_o", {30'd0, rd_exp[1:0]}, {30'd0, rd_resp_i}) &
             values_match("cfg_rd_ready_o", 32'd0, {31'd0, rd_ready_i});
        tally(ok, $sformatf("read %h", rd_exp[41:34]));
      end
    end
  end

endmodule

// ==== host_domain_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host domain LLC performance monitor
// Sizes and config register offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef HOST_DOMAIN_CONFIG_SVH
`define HOST_DOMAIN_CONFIG_SVH

`define NUM_LLC_EVENTS    4
`define PMU_CNT_WIDTH     32
`define PMU_CFG_AW        8
`define PMU_CFG_DW        32

// Word offsets in the config space
`define PMU_CTRL_OFFS     8'h00
`define PMU_THRESH_OFFS   8'h04
`define PMU_STATUS_OFFS   8'h08
`define PMU_CNT_BASE_OFFS 8'h10

`define PMU_BAD_READ_DATA 32'hdeadf000

`endif

// ==== host_domain_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host domain PMU types
// Event indices and the config word views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "host_domain_config.svh"

package host_domain_pkg;

  // Bit position of each LLC event strobe
  typedef enum logic [1:0] {
    LLC_RD_HIT  = 2'd0,
    LLC_RD_MISS = 2'd1,
    LLC_WR_HIT  = 2'd2,
    LLC_WR_MISS = 2'd3
  } llc_event_e;

  // Control register layout
  typedef struct packed {
    logic [`PMU_CFG_DW-`NUM_LLC_EVENTS-2:0] rsvd;
    logic                                   clr;
    logic [`NUM_LLC_EVENTS-1:0]             en;
  } pmu_ctrl_view_t;

  // Same word seen as control fields or as a plain number
  typedef union packed {
    pmu_ctrl_view_t         ctrl;
    logic [`PMU_CFG_DW-1:0] value;
  } pmu_cfg_word_u;

endpackage

// ==== host_domain_stim.txt ====
# cmd a b c, all hex: W addr data code | R addr expected-data expected-code
# E mask cycles 0 (event burst) | I level 0 0 (interrupt check)
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
R 1c 00000000 0
I 0 0 0
W 00 0000000f 0
E 5 00000006 0
R 10 00000006 0
R 14 00000000 0
R 18 00000006 0
W 00 00000019 0
R 00 00000009 0
E f 00000003 0
R 10 00000003 0
R 18 00000000 0
R 1c 00000003 0
W 04 00000005 0
E 1 00000002 0
I 1 0 0
R 08 00000001 0
W 08 00000001 0
I 0 0 0
R 08 00000000 0
R 20 deadf000 2
W 10 12345678 2
R 10 00000005 0

// ==== host_domain_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host domain PMU testbench
// Runs the stimulus file against the DUT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "host_domain_config.svh"

module host_domain_tb;

  localparam int TimeoutCycles = 40;

  logic                       clk_i;
  logic                       rst_n_i;
  logic [`NUM_LLC_EVENTS-1:0] llc_events_i;
  logic                       cfg_wr_valid_i;
  logic [`PMU_CFG_AW-1:0]     cfg_wr_addr_i;
  logic [`PMU_CFG_DW-1:0]     cfg_wr_data_i;
  logic                       cfg_wr_ready_o;
  logic                       cfg_wr_resp_valid_o;
  logic [1:0]                 cfg_wr_resp_o;
  logic                       cfg_wr_resp_ready_i;
  logic                       cfg_rd_valid_i;
  logic [`PMU_CFG_AW-1:0]     cfg_rd_addr_i;
  logic                       cfg_rd_ready_o;
  logic                       cfg_rd_resp_valid_o;
  logic [`PMU_CFG_DW-1:0]     cfg_rd_data_o;
  logic [1:0]                 cfg_rd_resp_o;
  logic                       cfg_rd_resp_ready_i;
  logic                       pmu_irq_o;
  integer                     seed = 32'h236b;
  bit                         aborted = 1'b0;

  host_domain dut (.*);

  host_domain_checker chk (
    .clk_i           ( clk_i               ),
    .wr_ready_i      ( cfg_wr_ready_o      ),
    .wr_resp_valid_i ( cfg_wr_resp_valid_o ),
    .wr_resp_ready_i ( cfg_wr_resp_ready_i ),
    .wr_resp_i       ( cfg_wr_resp_o       ),
    .rd_ready_i      ( cfg_rd_ready_o      ),
    .rd_resp_valid_i ( cfg_rd_resp_valid_o ),
    .rd_resp_ready_i ( cfg_rd_resp_ready_i ),
    .rd_data_i       ( cfg_rd_data_o       ),
    .rd_resp_i       ( cfg_rd_resp_o       ),
    .irq_i           ( pmu_irq_o           )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Drive point sits 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic transfer(input bit is_rd, input logic [7:0] addr, input logic [31:0] data);
    int n;
    bit done;
    bit vld;
    bit rdy;
    cfg_rd_valid_i = is_rd;
    cfg_rd_addr_i  = addr;
    cfg_wr_valid_i = !is_rd;
    cfg_wr_addr_i  = addr;
    cfg_wr_data_i  = data;
    done = 1'b0;
    for (n = 0; n < TimeoutCycles && !done; n++) begin
      done = is_rd ? cfg_rd_ready_o : cfg_wr_ready_o;
      next_cycle();
    end
    cfg_rd_valid_i = 1'b0;
    cfg_wr_valid_i = 1'b0;
    if (!done) begin
      chk.note_failure($sformatf("request to %h was never accepted", addr));
      aborted = 1'b1;
    end else begin
      done = 1'b0;
      // Random stalls on the response ready
      for (n = 0; n < TimeoutCycles && !done; n++) begin
        rdy = ($random(seed) % 3) != 0;
        vld = is_rd ? cfg_rd_resp_valid_o : cfg_wr_resp_valid_o;
        cfg_rd_resp_ready_i = is_rd & rdy;
        cfg_wr_resp_ready_i = !is_rd & rdy;
        next_cycle();
        done = vld & rdy;
      end
      cfg_rd_resp_ready_i = 1'b0;
      cfg_wr_resp_ready_i = 1'b0;
      if (!done) begin
        chk.note_failure($sformatf("no response arrived for request to %h", addr));
        aborted = 1'b1;
      end
    end
  endtask

  task automatic event_burst(input logic [3:0] mask, input int cycles);
    llc_events_i = mask;
    repeat (cycles) next_cycle();
    llc_events_i = '0;
  endtask

  initial begin
    int          fd;
    int          n;
    byte         cmd;
    logic [31:0] a, b, c;
    string       line;
    rst_n_i             = 1'b0;
    llc_events_i        = '0;
    cfg_wr_valid_i      = 1'b0;
    cfg_wr_addr_i       = '0;
    cfg_wr_data_i       = '0;
    cfg_wr_resp_ready_i = 1'b0;
    cfg_rd_valid_i      = 1'b0;
    cfg_rd_addr_i       = '0;
    cfg_rd_resp_ready_i = 1'b0;
    repeat (16) next_cycle();
    rst_n_i = 1'b1;
    fd = $fopen("host_domain_stim.txt", "r");
    if (fd == 0) begin
      chk.note_failure("cannot open host_domain_stim.txt");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() == 0 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%c %h %h %h", cmd, a, b, c);
      if (n != 4) continue;
      case (cmd)
        "W": begin
          chk.expect_write(a[7:0], c[1:0]);
          transfer(1'b0, a[7:0], b);
        end
        "R": begin
          chk.expect_read(a[7:0], b, c[1:0]);
          transfer(1'b1, a[7:0], '0);
        end
        "E": event_burst(a[3:0], b);
        "I": begin
          // Status lands first, the interrupt one cycle later
          repeat (2) next_cycle();
          chk.check_irq(a[0]);
        end
        default: chk.note_failure("unknown command in stimulus file");
      endcase
    end
    repeat (4) next_cycle();
    chk.print_counts();
    if (chk.fail_cnt == 0 && !aborted) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== pmu_cfg_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PMU config slave
// Valid/ready read and write channels,
// register strobes and read data mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "host_domain_config.svh"

module pmu_cfg_port (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic                                           cfg_wr_valid_i,
  input  logic [`PMU_CFG_AW-1:0]                         cfg_wr_addr_i,
  input  logic [`PMU_CFG_DW-1:0]                         cfg_wr_data_i,
  output logic                                           cfg_wr_ready_o,
  output logic                                           cfg_wr_resp_valid_o,
  output logic [1:0]                                     cfg_wr_resp_o,
  input  logic                                           cfg_wr_resp_ready_i,
  input  logic                                           cfg_rd_valid_i,
  input  logic [`PMU_CFG_AW-1:0]                         cfg_rd_addr_i,
  output logic                                           cfg_rd_ready_o,
  output logic                                           cfg_rd_resp_valid_o,
  output logic [`PMU_CFG_DW-1:0]                         cfg_rd_data_o,
  output logic [1:0]                                     cfg_rd_resp_o,
  input  logic                                           cfg_rd_resp_ready_i,
  output logic                                           ctrl_we_o,
  output logic                                           thresh_we_o,
  output logic                                           status_clr_we_o,
  output host_domain_pkg::pmu_cfg_word_u                 cfg_wdata_o,
  input  logic [`NUM_LLC_EVENTS-1:0]                     ctrl_q_i,
  input  logic [`PMU_CNT_WIDTH-1:0]                      thresh_q_i,
  input  logic [`NUM_LLC_EVENTS-1:0]                     status_q_i,
  input  logic [`NUM_LLC_EVENTS-1:0][`PMU_CNT_WIDTH-1:0] cnt_q_i
);
  import host_domain_pkg::*;

  localparam int unsigned CntIdxW  = $clog2(`NUM_LLC_EVENTS);
  localparam logic [1:0]  RespOkay = 2'd0;
  localparam logic [1:0]  RespErr  = 2'd2;

  logic                   wr_acc;
  logic                   rd_acc;
  logic                   wr_pend_q;
  logic                   rd_pend_q;
  logic [1:0]             wr_resp_q;
  logic [1:0]             rd_resp_q;
  logic [`PMU_CFG_DW-1:0] rd_data_q;
  logic [`PMU_CFG_DW-1:0] rd_data_d;
  logic                   wr_hit_ctrl;
  logic                   wr_hit_thresh;
  logic                   wr_hit_status;
  logic                   wr_mapped;
  logic [`PMU_CFG_AW-1:0] rd_cnt_offs;
  logic                   rd_hit_cnt;
  logic                   rd_mapped;
  pmu_cfg_word_u          ctrl_rd_word;

  // One response per channel, so ready simply mirrors the empty slot
  assign cfg_wr_ready_o = ~wr_pend_q;
  assign cfg_rd_ready_o = ~rd_pend_q;
  assign wr_acc         = cfg_wr_valid_i & cfg_wr_ready_o;
  assign rd_acc         = cfg_rd_valid_i & cfg_rd_ready_o;

  // Write decode, counters are read only
  assign wr_hit_ctrl     = (cfg_wr_addr_i == `PMU_CTRL_OFFS);
  assign wr_hit_thresh   = (cfg_wr_addr_i == `PMU_THRESH_OFFS);
  assign wr_hit_status   = (cfg_wr_addr_i == `PMU_STATUS_OFFS);
  assign wr_mapped       = wr_hit_ctrl | wr_hit_thresh | wr_hit_status;
  assign ctrl_we_o       = wr_acc & wr_hit_ctrl;
  assign thresh_we_o     = wr_acc & wr_hit_thresh;
  assign status_clr_we_o = wr_acc & wr_hit_status;
  assign cfg_wdata_o.value = cfg_wr_data_i;

  // Counter window, word aligned only
  assign rd_cnt_offs = cfg_rd_addr_i - `PMU_CNT_BASE_OFFS;
  assign rd_hit_cnt  = (cfg_rd_addr_i >= `PMU_CNT_BASE_OFFS) &&
                       (rd_cnt_offs[1:0] == 2'b00) &&
                       (rd_cnt_offs[`PMU_CFG_AW-1:2] < `NUM_LLC_EVENTS);

  always_comb begin
    ctrl_rd_word         = '0;
    ctrl_rd_word.ctrl.en = ctrl_q_i;
    rd_mapped            = 1'b1;
    rd_data_d            = `PMU_BAD_READ_DATA;
    if (rd_hit_cnt) begin
      rd_data_d = cnt_q_i[rd_cnt_offs[CntIdxW+1:2]];
    end else begin
      case (cfg_rd_addr_i)
        `PMU_CTRL_OFFS:   rd_data_d = ctrl_rd_word.value;
        `PMU_THRESH_OFFS: rd_data_d = thresh_q_i;
        `PMU_STATUS_OFFS: rd_data_d = {{(`PMU_CFG_DW-`NUM_LLC_EVENTS){1'b0}}, status_q_i};
        default:          rd_mapped = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      if (wr_acc) begin
        wr_pend_q <= 1'b1;
      end else if (cfg_wr_resp_ready_i) begin
        wr_pend_q <= 1'b0;
      end
      if (rd_acc) begin
        rd_pend_q <= 1'b1;
      end else if (cfg_rd_resp_ready_i) begin
        rd_pend_q <= 1'b0;
      end
    end
  end

  // Response payload, captured at acceptance
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      wr_resp_q <= wr_mapped ? RespOkay : RespErr;
    end
    if (rd_acc) begin
      rd_data_q <= rd_data_d;
      rd_resp_q <= rd_mapped ? RespOkay : RespErr;
    end
  end

  assign cfg_wr_resp_valid_o = wr_pend_q;
  assign cfg_wr_resp_o       = wr_resp_q;
  assign cfg_rd_resp_valid_o = rd_pend_q;
  assign cfg_rd_data_o       = rd_data_q;
  assign cfg_rd_resp_o       = rd_resp_q;

  property p_resp_hold(logic vld, logic rdy, logic [`PMU_CFG_DW+1:0] pay);
    @(posedge clk_i) disable iff (!rst_n_i)
      vld && !rdy |=> vld && $stable(pay);
  endproperty

  a_wr_resp_hold: assert property (p_resp_hold(cfg_wr_resp_valid_o, cfg_wr_resp_ready_i,
                                               {{`PMU_CFG_DW{1'b0}}, cfg_wr_resp_o}));
  a_rd_resp_hold: assert property (p_resp_hold(cfg_rd_resp_valid_o, cfg_rd_resp_ready_i,
                                               {cfg_rd_data_o, cfg_rd_resp_o}));

endmodule

// ==== pmu_counter_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PMU counter bank
// LLC event counters, threshold compare,
// sticky status and interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "host_domain_config.svh"

module pmu_counter_bank (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic [`NUM_LLC_EVENTS-1:0]                     llc_events_i,
  input  logic                                           ctrl_we_i,
  input  logic                                           thresh_we_i,
  input  logic                                           status_clr_we_i,
  input  host_domain_pkg::pmu_cfg_word_u                 cfg_wdata_i,
  output logic [`NUM_LLC_EVENTS-1:0]                     ctrl_q_o,
  output logic [`PMU_CNT_WIDTH-1:0]                      thresh_q_o,
  output logic [`NUM_LLC_EVENTS-1:0]                     status_q_o,
  output logic [`NUM_LLC_EVENTS-1:0][`PMU_CNT_WIDTH-1:0] cnt_q_o,
  output logic                                           pmu_irq_o
);

  logic [`NUM_LLC_EVENTS-1:0]                     en_q;
  logic [`PMU_CNT_WIDTH-1:0]                      thresh_q;
  logic [`NUM_LLC_EVENTS-1:0]                     status_q;
  logic [`NUM_LLC_EVENTS-1:0]                     status_d;
  logic [`NUM_LLC_EVENTS-1:0][`PMU_CNT_WIDTH-1:0] cnt_q;
  logic [`NUM_LLC_EVENTS-1:0][`PMU_CNT_WIDTH-1:0] cnt_d;
  logic [`NUM_LLC_EVENTS-1:0]                     cnt_inc;
  logic [`NUM_LLC_EVENTS-1:0]                     thr_hit;
  logic                                           cnt_clr;
  logic                                           irq_q;

  // Clear bit only acts on the write strobe, never stored
  assign cnt_clr = ctrl_we_i & cfg_wdata_i.ctrl.clr;
  assign cnt_inc = llc_events_i & en_q;

  // Counters wrap naturally at the top value
  always_comb begin
    for (int k = 0; k < `NUM_LLC_EVENTS; k++) begin
      cnt_d[k]   = cnt_q[k];
      thr_hit[k] = 1'b0;
      if (cnt_clr) begin
        cnt_d[k] = '0;
      end else if (cnt_inc[k]) begin
        cnt_d[k]   = cnt_q[k] + 1'b1;
        // Only a step onto the threshold counts as a hit
        thr_hit[k] = (thresh_q != '0) && (cnt_d[k] == thresh_q);
      end
    end
  end

  // Write one to clear, a new hit in the same cycle wins
  always_comb begin
    status_d = status_q;
    if (status_clr_we_i) begin
      status_d = status_d & ~cfg_wdata_i.value[`NUM_LLC_EVENTS-1:0];
    end
    status_d = status_d | thr_hit;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q     <= '0;
      thresh_q <= '0;
      cnt_q    <= '0;
      status_q <= '0;
      irq_q    <= 1'b0;
    end else begin
      if (ctrl_we_i) begin
        en_q <= cfg_wdata_i.ctrl.en;
      end
      if (thresh_we_i) begin
        thresh_q <= cfg_wdata_i.value;
      end
      cnt_q    <= cnt_d;
      status_q <= status_d;
      irq_q    <= |status_q;
    end
  end

  assign ctrl_q_o   = en_q;
  assign thresh_q_o = thresh_q;
  assign status_q_o = status_q;
  assign cnt_q_o    = cnt_q;
  assign pmu_irq_o  = irq_q;

  // Interrupt must trace back to a pending status bit one cycle earlier
  a_irq_from_status: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      pmu_irq_o |-> $past(status_q != '0)
  );

endmodule
